//--- project.f
+incdir+verification
verilog/isa_pkg.sv
verilog/mem_pkg.sv
verilog/mem_req_if.sv
verilog/fetch.sv
verilog/register_bank.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/data_bus.sv
verilog/cpu.sv
verification/cpu_tb.sv

//--- verification/tb_programs.svh
    // Every program ends with its result stored at 0x400 and a self-loop
    task fill_programs();
        start_program(0, "idle", 8'd0);
        emit(beq(0, 0, 0));

        start_program(1, "alu_forwarding", 8'h60);
        emit(addi(1, 0, 100));    // x1 = 0x64
        emit(addi(2, 1, 50));     // x2 = 0x96
        emit(add_rr(3, 1, 2));    // x3 = 0xFA
        emit(sub_rr(4, 3, 1));    // x4 = 0x96
        emit(and_rr(6, 4, 3));    // x6 = 0x92
        emit(or_rr(7, 6, 1));     // x7 = 0xF6
        emit(xor_rr(8, 7, 2));    // x8 = 0x60
        emit(addi(5, 0, 1024));
        emit(sw(8, 0, 5));
        emit(beq(0, 0, 0));

        start_program(2, "lui_immediates", 8'h35);
        emit(lui(1, 20'h00012));
        emit(addi(2, 1, -3));     // 0x11FFD
        emit(lui(3, 20'h00011));
        emit(sub_rr(4, 2, 3));    // 0xFFD
        emit(addi(4, 4, -200));   // 0xF35
        emit(addi(5, 0, 1024));
        emit(sw(4, 0, 5));
        emit(beq(0, 0, 0));

        start_program(3, "load_use", 8'd154);
        emit(addi(1, 0, 77));
        emit(addi(2, 0, 64));
        emit(sw(1, 0, 2));
        emit(lw(3, 0, 2));
        emit(add_rr(4, 3, 3));    // Needs the loaded value at once
        emit(addi(5, 0, 1024));
        emit(sw(4, 0, 5));
        emit(beq(0, 0, 0));

        start_program(4, "store_burst", 8'd88);
        emit(addi(1, 0, 11));
        emit(addi(2, 0, 22));
        emit(addi(3, 0, 33));
        emit(addi(4, 0, 44));
        emit(sw(1, 0, 0));        // Four stores in a row run out of credits
        emit(sw(2, 4, 0));
        emit(sw(3, 8, 0));
        emit(sw(4, 12, 0));
        emit(lw(6, 4, 0));
        emit(lw(7, 12, 0));
        emit(add_rr(8, 6, 7));    // 66
        emit(lw(9, 8, 0));
        emit(add_rr(8, 8, 9));    // 99
        emit(lw(10, 0, 0));
        emit(sub_rr(8, 8, 10));   // 88
        emit(addi(5, 0, 1024));
        emit(sw(8, 0, 5));
        emit(beq(0, 0, 0));

        start_program(5, "beq_taken", 8'hA0);
        branch_program(1'b0, 12'd9);
        start_program(6, "beq_not_taken", 8'hF5);
        branch_program(1'b0, 12'd10);
        start_program(7, "bne_taken", 8'hA0);
        branch_program(1'b1, 12'd10);
        start_program(8, "bne_not_taken", 8'hF5);
        branch_program(1'b1, 12'd9);
    endtask

    // Taken path skips two adds and leaves 0xA0, fall-through gives 0xF5
    task branch_program(input logic use_bne, input logic [11:0] rhs);
        emit(addi(3, 0, 12'h020));
        emit(addi(1, 0, 9));
        emit(addi(2, 0, rhs));
        emit(use_bne ? bne(1, 2, 12) : beq(1, 2, 12));
        emit(addi(3, 3, 12'h011));
        emit(addi(3, 3, 12'h044));
        emit(addi(3, 3, 12'h080));    // Branch target
        emit(addi(5, 0, 1024));
        emit(sw(3, 0, 5));
        emit(beq(0, 0, 0));
    endtask

//--- verification/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import mem_pkg::*;

    localparam int NUM_PROGRAMS = 9;
    localparam int PROG_WORDS   = 32;
    localparam int RUN_TIMEOUT  = 2000;    // Cycles allowed to reach the final loop
    localparam int PWM_WINDOW   = 256;
    localparam int LOOP_ENTRIES = 4;       // Loop passes until earlier stores have retired

    logic       clock;
    logic       rst_n;
    logic       enable;
    instr_t     rom_data;
    logic [7:0] rom_address;
    logic       port_pwm1;

    instr_t    rom [256];
    instr_t    programs [NUM_PROGRAMS][PROG_WORDS];
    pwm_duty_t expected_duty [NUM_PROGRAMS];
    string     names [NUM_PROGRAMS];
    int        loop_word [NUM_PROGRAMS];    // Word index of the final self-loop
    int        cur_prog;
    int        cur_word;
    int        mismatch_count;
    int        timeout_count;
    int        seed = 32'h12c8d22b;

    cpu cpu_inst (
        .clock(clock),
        .rst_n(rst_n),
        .enable(enable),
        .rom_data(rom_data),
        .rom_address(rom_address),
        .port_pwm1(port_pwm1)
    );

    assign rom_data = rom[rom_address];    // Asynchronous instruction ROM

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // RV32I encodings of the supported subset
    function automatic instr_t r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input reg_idx_t rd, rs1, rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic instr_t b_type(input logic [2:0] funct3, input reg_idx_t rs1, rs2,
                                      input logic [12:0] offset);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
                7'b1100011};
    endfunction

    function automatic instr_t add_rr(input reg_idx_t rd, rs1, rs2);
        return r_type(7'b0000000, 3'b000, rd, rs1, rs2);
    endfunction

    function automatic instr_t sub_rr(input reg_idx_t rd, rs1, rs2);
        return r_type(7'b0100000, 3'b000, rd, rs1, rs2);
    endfunction

    function automatic instr_t and_rr(input reg_idx_t rd, rs1, rs2);
        return r_type(7'b0000000, 3'b111, rd, rs1, rs2);
    endfunction

    function automatic instr_t or_rr(input reg_idx_t rd, rs1, rs2);
        return r_type(7'b0000000, 3'b110, rd, rs1, rs2);
    endfunction

    function automatic instr_t xor_rr(input reg_idx_t rd, rs1, rs2);
        return r_type(7'b0000000, 3'b100, rd, rs1, rs2);
    endfunction

    function automatic instr_t addi(input reg_idx_t rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic instr_t lui(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic instr_t lw(input reg_idx_t rd, input logic [11:0] imm,
                                  input reg_idx_t rs1);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic instr_t sw(input reg_idx_t rs2, input logic [11:0] imm,
                                  input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic instr_t beq(input reg_idx_t rs1, rs2, input logic [12:0] offset);
        return b_type(3'b000, rs1, rs2, offset);
    endfunction

    function automatic instr_t bne(input reg_idx_t rs1, rs2, input logic [12:0] offset);
        return b_type(3'b001, rs1, rs2, offset);
    endfunction

    task start_program(input int idx, input string name, input pwm_duty_t duty);
        cur_prog           = idx;
        cur_word           = 0;
        names[idx]         = name;
        expected_duty[idx] = duty;
    endtask

    task emit(input instr_t word);
        programs[cur_prog][cur_word] = word;
        loop_word[cur_prog]          = cur_word;    // Last word is the self-loop
        cur_word++;
    endtask

    `include "tb_programs.svh"

    task check_duty(input pwm_duty_t got, input pwm_duty_t expected, input string what);
        if (got !== expected) begin
            $display("Mismatch at %0d ns: %s, got %0d, expected %0d", $time, what, got,
                     expected);
            mismatch_count++;
        end
    endtask

    task check_address(input logic [7:0] got, input logic [7:0] expected, input string what);
        if (got !== expected) begin
            $display("Mismatch at %0d ns: %s, got %0d, expected %0d", $time, what, got,
                     expected);
            mismatch_count++;
        end
    endtask

    task check_level(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("Mismatch at %0d ns: %s, got %b, expected %b", $time, what, got,
                     expected);
            mismatch_count++;
        end
    endtask

    task load_rom(input int t);
        for (int i = 0; i < 256; i++) begin
            if (i <= loop_word[t]) begin
                rom[i] = programs[t][i];
            end else begin
                rom[i] = addi(0, 0, i);    // NOP carrying its own word index
            end
        end
    endtask

    task restart(input int t);
        @(negedge clock);
        rst_n  = 1'b0;
        enable = 1'b1;
        load_rom(t);
        repeat (8) @(negedge clock);
        rst_n = 1'b1;
    endtask

    task freeze_enable(input int cycles, input string name);
        logic [7:0] frozen_address;
        logic       frozen_pwm;
        enable         = 1'b0;
        frozen_address = rom_address;
        frozen_pwm     = port_pwm1;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            check_address(rom_address, frozen_address, {name, ": rom_address while disabled"});
            check_level(port_pwm1, frozen_pwm, {name, ": port_pwm1 while disabled"});
        end
        enable = 1'b1;
    endtask

    task wait_for_loop(input logic [7:0] loop_address, output bit reached);
        int         entries;
        int         cycles;
        logic [7:0] previous;
        entries  = 0;
        cycles   = 0;
        previous = rom_address;
        while (entries < LOOP_ENTRIES && cycles < RUN_TIMEOUT) begin
            @(negedge clock);
            if (rom_address == loop_address && previous != loop_address) begin
                entries++;
            end
            previous = rom_address;
            cycles++;
        end
        reached = (entries == LOOP_ENTRIES);
    endtask

    // One full turn of the 8-bit counter
    task measure_pwm(output int high_cycles);
        high_cycles = 0;
        for (int i = 0; i < PWM_WINDOW; i++) begin
            @(negedge clock);
            if (port_pwm1 === 1'b1) begin
                high_cycles++;
            end
        end
    endtask

    initial begin
        int delay;
        int freeze_cycles;
        int high_cycles;
        bit reached;
        rst_n          = 1'b0;
        enable         = 1'b0;
        mismatch_count = 0;
        timeout_count  = 0;
        fill_programs();
        load_rom(0);
        for (int t = 0; t < NUM_PROGRAMS; t++) begin
            restart(t);
            check_address(rom_address, 8'd0, {names[t], ": rom_address after reset"});
            delay         = $random(seed) & 7;
            freeze_cycles = 1 + ($random(seed) & 31);
            repeat (delay) @(negedge clock);
            freeze_enable(freeze_cycles, names[t]);
            wait_for_loop(8'(loop_word[t]), reached);
            if (!reached) begin
                $display("Timeout: program %s never reached its final loop at word %0d",
                         names[t], loop_word[t]);
                timeout_count++;
            end else begin
                // Longer than a counter turn, so a running counter would move port_pwm1
                freeze_enable(PWM_WINDOW + freeze_cycles, names[t]);
                measure_pwm(high_cycles);
                if (high_cycles > 255) begin
                    $display("Mismatch at %0d ns: %s, port_pwm1 high for all %0d cycles",
                             $time, names[t], high_cycles);
                    mismatch_count++;
                end else begin
                    check_duty(pwm_duty_t'(high_cycles), expected_duty[t],
                               {names[t], ": measured duty"});
                end
            end
        end
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/cpu.sv
module cpu #(
    parameter int RAM_WORDS   = 256,
    parameter int RAM_WAIT    = 1,
    parameter int MEM_CREDITS = 2
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            enable,
    input  isa_pkg::instr_t rom_data,
    output logic [7:0]      rom_address,
    output logic            port_pwm1
);
    import isa_pkg::*;
    import mem_pkg::*;

    // Fetch to decode
    addr_t    if_pc;
    instr_t   if_instr;
    logic     if_valid;

    reg_idx_t rb_rs1, rb_rs2;
    word_t    rb_value1, rb_value2;

    // Decode to execute
    word_t    ex_op1, ex_op2, ex_imm;
    reg_idx_t ex_rs1, ex_rs2, ex_rd;
    alu_op_e  ex_alu_op;
    logic     ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write;
    branch_e  ex_branch;
    addr_t    ex_pc;

    // Execute to memory
    word_t    mem_result, mem_store_data;
    reg_idx_t mem_rd;
    logic     mem_reg_write, mem_read, mem_write;

    logic     branch_taken;
    addr_t    branch_target;
    logic     mem_stall, hold, fetch_stall;
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    mem_req_if mem_bus ();

    assign fetch_stall = mem_stall || hold;    // Load-use bubble also holds fetch

    fetch fetch_inst (
        .clock(clock), .rst_n(rst_n), .enable(enable), .stall(fetch_stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .rom_data(rom_data), .rom_address(rom_address),
        .pc(if_pc), .instr(if_instr), .valid(if_valid)
    );

    register_bank register_bank_inst (
        .clock(clock), .rst_n(rst_n), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .rs1(rb_rs1), .rs2(rb_rs2), .value1(rb_value1), .value2(rb_value2)
    );

    decode decode_inst (
        .clock(clock), .rst_n(rst_n), .enable(enable), .stall(mem_stall),
        .flush(branch_taken), .instr(if_instr), .pc(if_pc), .valid(if_valid),
        .value1(rb_value1), .value2(rb_value2), .rs1(rb_rs1), .rs2(rb_rs2), .hold(hold),
        .ex_op1(ex_op1), .ex_op2(ex_op2), .ex_imm(ex_imm),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write),
        .ex_branch(ex_branch), .ex_pc(ex_pc)
    );

    execute execute_inst (
        .clock(clock), .rst_n(rst_n), .enable(enable), .stall(mem_stall),
        .ex_op1(ex_op1), .ex_op2(ex_op2), .ex_imm(ex_imm),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_alu_op(ex_alu_op), .ex_alu_src(ex_alu_src), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .ex_reg_write(ex_reg_write),
        .ex_branch(ex_branch), .ex_pc(ex_pc),
        .fwd_mem_en(mem_reg_write), .fwd_mem_rd(mem_rd), .fwd_mem_data(mem_result),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write), .mem_read(mem_read), .mem_write(mem_write)
    );

    memory #(.MEM_CREDITS(MEM_CREDITS)) memory_inst (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .mem_result(mem_result), .mem_store_data(mem_store_data), .mem_rd(mem_rd),
        .mem_reg_write(mem_reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .bus(mem_bus.stage), .stall(mem_stall),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    data_bus #(
        .RAM_WORDS(RAM_WORDS),
        .RAM_WAIT(RAM_WAIT),
        .MEM_CREDITS(MEM_CREDITS)
    ) data_bus_inst (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .bus(mem_bus.bus), .port_pwm1(port_pwm1)
    );

endmodule

//--- verilog/data_bus.sv
module data_bus #(
    parameter int RAM_WORDS   = 256,
    parameter int RAM_WAIT    = 1,
    parameter int MEM_CREDITS = 2
) (
    input  logic   clock,
    input  logic   rst_n,
    input  logic   enable,
    mem_req_if.bus bus,
    output logic   port_pwm1
);
    import mem_pkg::*;

    localparam int PTR_W  = (MEM_CREDITS > 1) ? $clog2(MEM_CREDITS) : 1;
    localparam int CNT_W  = $clog2(MEM_CREDITS + 1);
    localparam int WAIT_W = $clog2(RAM_WAIT + 2);
    localparam int IDX_W  = $clog2(RAM_WORDS);

    logic              fifo_write [MEM_CREDITS];
    addr_t             fifo_addr  [MEM_CREDITS];
    word_t             fifo_wdata [MEM_CREDITS];
    word_t             ram        [RAM_WORDS];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic [WAIT_W-1:0] wait_q;
    pwm_duty_t         duty_q;
    pwm_duty_t         pwm_cnt_q;
    logic              retire;
    addr_t             head_addr;
    logic [IDX_W-1:0]  head_idx;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(MEM_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_addr = fifo_addr[rd_ptr_q];
    assign head_idx  = head_addr[IDX_W+1:2];
    assign retire    = enable && count_q != '0 && wait_q == WAIT_W'(RAM_WAIT);

    assign bus.credit    = retire;
    assign bus.rsp_valid = retire && !fifo_write[rd_ptr_q];
    assign bus.rsp_rdata = (head_addr == PWM_ADDR) ? word_t'(duty_q) : ram[head_idx];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            wait_q    <= '0;
            duty_q    <= '0;
            pwm_cnt_q <= '0;
        end else begin
            if (bus.req_valid) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (retire) rd_ptr_q <= next_ptr(rd_ptr_q);
            count_q <= count_q + CNT_W'(bus.req_valid) - CNT_W'(retire);
            if (retire) begin
                wait_q <= '0;
            end else if (enable && count_q != '0) begin
                wait_q <= wait_q + 1'b1;    // Wait states of the head request
            end
            if (retire && fifo_write[rd_ptr_q] && head_addr == PWM_ADDR) begin
                duty_q <= fifo_wdata[rd_ptr_q][$bits(pwm_duty_t)-1:0];
            end
            if (enable) pwm_cnt_q <= pwm_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.req_valid) begin
            fifo_write[wr_ptr_q] <= bus.req_write;
            fifo_addr[wr_ptr_q]  <= bus.req_addr;
            fifo_wdata[wr_ptr_q] <= bus.req_wdata;
        end
        if (retire && fifo_write[rd_ptr_q] && head_addr < PWM_ADDR) begin
            ram[head_idx] <= fifo_wdata[rd_ptr_q];
        end
    end

    assign port_pwm1 = (pwm_cnt_q < duty_q);

    // Credit accounting in the memory stage keeps the buffer from overflowing
    assert property (@(posedge clock) disable iff (!rst_n)
        bus.req_valid |-> count_q < CNT_W'(MEM_CREDITS));

endmodule

//--- verilog/decode.sv
module decode (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              stall,
    input  logic              flush,
    input  isa_pkg::instr_t   instr,
    input  mem_pkg::addr_t    pc,
    input  logic              valid,
    input  mem_pkg::word_t    value1,
    input  mem_pkg::word_t    value2,
    output isa_pkg::reg_idx_t rs1,
    output isa_pkg::reg_idx_t rs2,
    output logic              hold,
    output mem_pkg::word_t    ex_op1,
    output mem_pkg::word_t    ex_op2,
    output mem_pkg::word_t    ex_imm,
    output isa_pkg::reg_idx_t ex_rs1,
    output isa_pkg::reg_idx_t ex_rs2,
    output isa_pkg::reg_idx_t ex_rd,
    output isa_pkg::alu_op_e  ex_alu_op,
    output logic              ex_alu_src,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_reg_write,
    output isa_pkg::branch_e  ex_branch,
    output mem_pkg::addr_t    ex_pc
);
    import isa_pkg::*;
    import mem_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    reg_idx_t   rd;
    word_t      imm;
    alu_op_e    alu_op;
    logic       alu_src;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    branch_e    branch;
    logic       advance;
    logic       issue;

    function automatic alu_op_e funct_op(input logic [2:0] f3, input logic sub);
        alu_op_e op;
        case (f3)
            F3_XOR:  op = ALU_XOR;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = sub ? ALU_SUB : ALU_ADD;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Load in execute feeding this instruction costs one bubble
    assign hold    = valid && ex_mem_read && (ex_rd == rs1 || ex_rd == rs2);
    assign advance = enable && !stall;
    assign issue   = valid && !flush && !hold;

    always_comb begin
        alu_op    = ALU_ADD;
        alu_src   = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = BR_NONE;
        imm       = {{20{instr[31]}}, instr[31:20]};    // I-type
        case (opcode)
            OP_R: begin
                alu_src   = 1'b0;
                reg_write = 1'b1;
                alu_op    = funct_op(funct3, instr[30]);
            end
            OP_I: begin
                reg_write = 1'b1;
                alu_op    = funct_op(funct3, 1'b0);
            end
            OP_LUI: begin
                reg_write = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = {instr[31:12], 12'b0};
            end
            OP_LOAD: begin
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_STORE: begin
                mem_write = 1'b1;
                imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OP_BRANCH: begin
                alu_src = 1'b0;
                branch  = (funct3 == F3_BNE) ? BR_NE : BR_EQ;
                imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            default: ;    // Unsupported opcodes run as NOP
        endcase
        if (rd == '0) begin
            reg_write = 1'b0;    // Keeps x0 out of forwarding too
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_branch    <= BR_NONE;
        end else if (advance) begin
            ex_mem_read  <= issue && mem_read;
            ex_mem_write <= issue && mem_write;
            ex_reg_write <= issue && reg_write;
            ex_branch    <= issue ? branch : BR_NONE;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            ex_op1     <= value1;
            ex_op2     <= value2;
            ex_imm     <= imm;
            ex_rs1     <= rs1;
            ex_rs2     <= rs2;
            ex_rd      <= rd;
            ex_alu_op  <= alu_op;
            ex_alu_src <= alu_src;
            ex_pc      <= pc;
        end
    end

endmodule

//--- verilog/execute.sv
module execute (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enable,
    input  logic              stall,
    input  mem_pkg::word_t    ex_op1,
    input  mem_pkg::word_t    ex_op2,
    input  mem_pkg::word_t    ex_imm,
    input  isa_pkg::reg_idx_t ex_rs1,
    input  isa_pkg::reg_idx_t ex_rs2,
    input  isa_pkg::reg_idx_t ex_rd,
    input  isa_pkg::alu_op_e  ex_alu_op,
    input  logic              ex_alu_src,
    input  logic              ex_mem_read,
    input  logic              ex_mem_write,
    input  logic              ex_reg_write,
    input  isa_pkg::branch_e  ex_branch,
    input  mem_pkg::addr_t    ex_pc,
    input  logic              fwd_mem_en,
    input  isa_pkg::reg_idx_t fwd_mem_rd,
    input  mem_pkg::word_t    fwd_mem_data,
    input  logic              wb_en,
    input  isa_pkg::reg_idx_t wb_rd,
    input  mem_pkg::word_t    wb_data,
    output logic              branch_taken,
    output mem_pkg::addr_t    branch_target,
    output mem_pkg::word_t    mem_result,
    output mem_pkg::word_t    mem_store_data,
    output isa_pkg::reg_idx_t mem_rd,
    output logic              mem_reg_write,
    output logic              mem_read,
    output logic              mem_write
);
    import isa_pkg::*;
    import mem_pkg::*;

    word_t src1;
    word_t src2;
    word_t operand_b;
    word_t alu_out;
    logic  equal;
    logic  advance;

    // Newest producer wins
    function automatic word_t forward(input reg_idx_t rs, input word_t reg_value);
        word_t value;
        if (fwd_mem_en && fwd_mem_rd == rs) begin
            value = fwd_mem_data;
        end else if (wb_en && wb_rd == rs) begin
            value = wb_data;
        end else begin
            value = reg_value;
        end
        return value;
    endfunction

    assign src1      = forward(ex_rs1, ex_op1);
    assign src2      = forward(ex_rs2, ex_op2);
    assign operand_b = ex_alu_src ? ex_imm : src2;
    assign advance   = enable && !stall;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB:    alu_out = src1 - operand_b;
            ALU_AND:    alu_out = src1 & operand_b;
            ALU_OR:     alu_out = src1 | operand_b;
            ALU_XOR:    alu_out = src1 ^ operand_b;
            ALU_PASS_B: alu_out = operand_b;
            default:    alu_out = src1 + operand_b;
        endcase
    end

    assign equal         = (src1 == src2);
    assign branch_taken  = (ex_branch == BR_EQ && equal) || (ex_branch == BR_NE && !equal);
    assign branch_target = ex_pc + ex_imm;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
        end else if (advance) begin
            mem_reg_write <= ex_reg_write;
            mem_read      <= ex_mem_read;
            mem_write     <= ex_mem_write;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            mem_result     <= alu_out;
            mem_store_data <= src2;
            mem_rd         <= ex_rd;
        end
    end

    // Slot behind a taken branch arrives flushed, never as a live instruction
    assert property (@(posedge clock) disable iff (!rst_n)
        advance && branch_taken |=> ex_branch == BR_NONE && !ex_reg_write
                                     && !ex_mem_read && !ex_mem_write);

endmodule

//--- verilog/fetch.sv
module fetch (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            enable,
    input  logic            stall,
    input  logic            branch_taken,
    input  mem_pkg::addr_t  branch_target,
    input  isa_pkg::instr_t rom_data,
    output logic [7:0]      rom_address,
    output mem_pkg::addr_t  pc,
    output isa_pkg::instr_t instr,
    output logic            valid
);
    import mem_pkg::*;

    addr_t pc_q;
    logic  advance;

    assign advance     = enable && !stall;
    assign rom_address = pc_q[9:2];    // Word index into the ROM

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc_q  <= '0;
            valid <= 1'b0;
        end else if (advance) begin
            pc_q  <= branch_taken ? branch_target : pc_q + 32'd4;
            valid <= !branch_taken;    // Word in flight is on the wrong path
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            instr <= rom_data;
            pc    <= pc_q;
        end
    end

endmodule

//--- verilog/isa_pkg.sv
package isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B    // LUI, immediate straight through
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_e;

    // funct3 codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BNE = 3'b001;

endpackage

//--- verilog/mem_pkg.sv
package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // PWM duty and free-running counter
    typedef logic [7:0] pwm_duty_t;

    // Duty register, everything below is RAM
    localparam addr_t PWM_ADDR = 32'h0000_0400;

endpackage

//--- verilog/mem_req_if.sv
interface mem_req_if;
    import mem_pkg::*;

    logic  req_valid;    // One cycle, spends a credit
    logic  req_write;
    addr_t req_addr;
    word_t req_wdata;

    logic  credit;       // Pulse per retired request
    logic  rsp_valid;    // Load data, in order
    word_t rsp_rdata;

    modport stage (
        output req_valid, req_write, req_addr, req_wdata,
        input  credit, rsp_valid, rsp_rdata
    );

    modport bus (
        input  req_valid, req_write, req_addr, req_wdata,
        output credit, rsp_valid, rsp_rdata
    );

endinterface

//--- verilog/memory.sv
module memory #(
    parameter int MEM_CREDITS = 2
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enable,
    input  mem_pkg::word_t    mem_result,
    input  mem_pkg::word_t    mem_store_data,
    input  isa_pkg::reg_idx_t mem_rd,
    input  logic              mem_reg_write,
    input  logic              mem_read,
    input  logic              mem_write,
    mem_req_if.stage          bus,
    output logic              stall,
    output logic              wb_en,
    output isa_pkg::reg_idx_t wb_rd,
    output mem_pkg::word_t    wb_data
);
    localparam int CREDIT_W = $clog2(MEM_CREDITS + 1);

    logic [CREDIT_W-1:0] credits_q;
    logic                issued_q;    // Request of the current instruction already sent
    logic                mem_op;
    logic                advance;

    assign mem_op = mem_read || mem_write;

    assign bus.req_valid = enable && mem_op && !issued_q && credits_q != '0;
    assign bus.req_write = mem_write;
    assign bus.req_addr  = mem_result;
    assign bus.req_wdata = mem_store_data;

    // Out of credits, or a load still waiting for its data
    assign stall   = (mem_op && !issued_q && credits_q == '0)
                  || (mem_read && !(issued_q && bus.rsp_valid));
    assign advance = enable && !stall;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= CREDIT_W'(MEM_CREDITS);
            issued_q  <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            if (bus.req_valid && !bus.credit) begin
                credits_q <= credits_q - 1'b1;
            end else if (bus.credit && !bus.req_valid) begin
                credits_q <= credits_q + 1'b1;
            end
            if (advance) begin
                issued_q <= 1'b0;
                wb_en    <= mem_reg_write;
            end else if (bus.req_valid) begin
                issued_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            wb_rd   <= mem_rd;
            wb_data <= mem_read ? bus.rsp_rdata : mem_result;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n)
        credits_q <= CREDIT_W'(MEM_CREDITS));

    // Load data only ever meets a load that has been issued
    assert property (@(posedge clock) disable iff (!rst_n)
        bus.rsp_valid |-> mem_read && issued_q);

endmodule

//--- verilog/register_bank.sv
module register_bank (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              wb_en,
    input  isa_pkg::reg_idx_t wb_rd,
    input  mem_pkg::word_t    wb_data,
    input  isa_pkg::reg_idx_t rs1,
    input  isa_pkg::reg_idx_t rs2,
    output mem_pkg::word_t    value1,
    output mem_pkg::word_t    value2
);
    import mem_pkg::*;

    word_t regs [32];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // x0 is hardwired, a same-cycle write is seen at once
    assign value1 = (rs1 == '0) ? '0 : (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign value2 = (rs2 == '0) ? '0 : (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule
